//--- logic/core_pkg.sv
package core_pkg;

    // datapath sizes
    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    // one register value
    typedef logic [data_width-1:0] data_t;

    // one architectural register number
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // decode read request, up to two sources per cycle
    typedef struct packed {
        logic      inst_valid;
        logic      r1_en;
        reg_addr_t r1_addr;
        logic      r2_en;
        reg_addr_t r2_addr;
    } src_req_t;

    // result record of one later stage (ex, mem or wb)
    typedef struct packed {
        logic      valid;
        logic      rw_en;
        // load result, data only real once it reaches writeback
        logic      is_load;
        reg_addr_t rw_addr;
        data_t     rw_data;
    } fwd_rec_t;

    // operand pair handed to execute
    typedef struct packed {
        logic  valid;
        data_t op1;
        data_t op2;
    } issue_t;

endpackage : core_pkg

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clock,
    input  logic               reset,
    input  core_pkg::reg_addr_t rd1_addr,
    input  core_pkg::reg_addr_t rd2_addr,
    output core_pkg::data_t     rd1_data,
    output core_pkg::data_t     rd2_data,
    input  core_pkg::fwd_rec_t  wb_rec
);
    import core_pkg::*;

    data_t regs [reg_count];
    logic  wr_en;

    // writeback commit, r0 is never written
    assign wr_en = wb_rec.valid && wb_rec.rw_en && (wb_rec.rw_addr != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rec.rw_addr] <= wb_rec.rw_data;
        end
    end

    // two combinational read ports
    // a write in this cycle is not seen here yet, the wb forward covers it
    always_comb begin
        if (rd1_addr == '0) begin
            rd1_data = '0;
        end else begin
            rd1_data = regs[rd1_addr];
        end
    end

    always_comb begin
        if (rd2_addr == '0) begin
            rd2_data = '0;
        end else begin
            rd2_data = regs[rd2_addr];
        end
    end

endmodule : reg_file

//--- logic/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  logic                src_en,
    input  core_pkg::reg_addr_t src_addr,
    input  core_pkg::data_t     rf_data,
    input  core_pkg::fwd_rec_t  ex_rec,
    input  core_pkg::fwd_rec_t  mem_rec,
    input  core_pkg::fwd_rec_t  wb_rec,
    output core_pkg::data_t     operand,
    output logic                hazard
);
    import core_pkg::*;

    logic src_live;
    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    // record targets this source register
    function automatic logic rec_hits(input fwd_rec_t rec, input reg_addr_t addr);
        return rec.valid && rec.rw_en && (rec.rw_addr == addr);
    endfunction

    // disabled reads and r0 never forward and never stall
    assign src_live = src_en && (src_addr != '0);

    assign ex_hit  = src_live && rec_hits(ex_rec, src_addr);
    assign mem_hit = src_live && rec_hits(mem_rec, src_addr);
    assign wb_hit  = src_live && rec_hits(wb_rec, src_addr);

    // newest result wins, ex over mem over wb
    always_comb begin
        operand = rf_data;
        hazard  = 1'b0;
        if (!src_live) begin
            operand = '0;
        end else if (ex_hit) begin
            operand = ex_rec.rw_data;
            // load still in execute, data not there yet
            hazard  = ex_rec.is_load;
        end else if (mem_hit) begin
            operand = mem_rec.rw_data;
            // load in memory stage, data returns in writeback
            hazard  = mem_rec.is_load;
        end else if (wb_hit) begin
            // loads have their data by writeback
            operand = wb_rec.rw_data;
        end
    end

endmodule : operand_bypass

//--- logic/operand_issue.sv
`timescale 1ns/1ps

module operand_issue (
    input  logic              clock,
    input  logic              reset,
    input  logic              inst_valid,
    input  logic              hazard1,
    input  logic              hazard2,
    input  core_pkg::data_t   op1,
    input  core_pkg::data_t   op2,
    output logic              id_stall,
    output core_pkg::issue_t  issue
);
    import core_pkg::*;

    logic  valid_q;
    data_t op1_q;
    data_t op2_q;

    // hold decode when nothing to issue or a load result is pending
    assign id_stall = !inst_valid || hazard1 || hazard2;

    // a stalled cycle becomes a bubble toward execute
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= !id_stall;
        end
    end

    // operand pair only loads on a real issue
    always_ff @(posedge clock) begin
        if (!id_stall) begin
            op1_q <= op1;
            op2_q <= op2;
        end
    end

    assign issue = '{valid: valid_q, op1: op1_q, op2: op2_q};

endmodule : operand_issue

//--- logic/operand_fetch.sv
`timescale 1ns/1ps

module operand_fetch (
    input  logic               clock,
    input  logic               reset,
    input  core_pkg::src_req_t req,
    input  core_pkg::fwd_rec_t ex_rec,
    input  core_pkg::fwd_rec_t mem_rec,
    input  core_pkg::fwd_rec_t wb_rec,
    output logic               id_stall,
    output core_pkg::issue_t   issue
);
    import core_pkg::*;

    // register file read values
    data_t rf_data1;
    data_t rf_data2;

    // bypassed operands and load-use flags
    data_t op1;
    data_t op2;
    logic  hazard1;
    logic  hazard2;

    reg_file i_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rd1_addr (req.r1_addr),
        .rd2_addr (req.r2_addr),
        .rd1_data (rf_data1),
        .rd2_data (rf_data2),
        .wb_rec   (wb_rec)
    );

    // source 1
    operand_bypass bypass_1 (
        .src_en   (req.r1_en),
        .src_addr (req.r1_addr),
        .rf_data  (rf_data1),
        .ex_rec   (ex_rec),
        .mem_rec  (mem_rec),
        .wb_rec   (wb_rec),
        .operand  (op1),
        .hazard   (hazard1)
    );

    // source 2, same records as source 1
    operand_bypass bypass_2 (
        .src_en   (req.r2_en),
        .src_addr (req.r2_addr),
        .rf_data  (rf_data2),
        .ex_rec   (ex_rec),
        .mem_rec  (mem_rec),
        .wb_rec   (wb_rec),
        .operand  (op2),
        .hazard   (hazard2)
    );

    operand_issue i_issue (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (req.inst_valid),
        .hazard1    (hazard1),
        .hazard2    (hazard2),
        .op1        (op1),
        .op2        (op2),
        .id_stall   (id_stall),
        .issue      (issue)
    );

endmodule : operand_fetch

//--- tests/operand_fetch_assertions.sv
`timescale 1ns/1ps

module operand_fetch_assertions (
    input logic clock,
    input logic reset,
    input logic inst_valid,
    input logic id_stall,
    input logic issue_valid
);

    // failed assertions so far
    int failures = 0;

    // reset empties the issue register
    reset_clears_issue: assert property (
        @(posedge clock) reset |=> !issue_valid
    ) else begin
        $error("issue.valid set in the cycle after reset");
        failures++;
    end

    // a stalled cycle turns into a bubble
    stall_gives_bubble: assert property (
        @(posedge clock) disable iff (reset) id_stall |=> !issue_valid
    ) else begin
        $error("issue.valid set in the cycle after a stall");
        failures++;
    end

    // clean decode cycle always issues
    clean_cycle_issues: assert property (
        @(posedge clock) disable iff (reset) (inst_valid && !id_stall) |=> issue_valid
    ) else begin
        $error("issue.valid low after an unstalled valid instruction");
        failures++;
    end

endmodule : operand_fetch_assertions

//--- tests/operand_fetch_tb.sv
`timescale 1ns/1ps

module operand_fetch_tb;
    import core_pkg::*;

    // where an operand comes from
    typedef enum int {src_zero, src_ex, src_mem, src_wb, src_rf} src_sel_e;

    logic     clock;
    logic     reset;
    src_req_t req;
    fwd_rec_t ex_rec;
    fwd_rec_t mem_rec;
    fwd_rec_t wb_rec;
    logic     id_stall;
    issue_t   issue;

    data_t       shadow [reg_count];
    int          stall_errors     = 0;
    int          issue_errors     = 0;
    int          assertion_errors = 0;
    int          total_errors;
    int unsigned cycle_count  = 0;
    int unsigned cycle_limit  = 400;

    operand_fetch i_dut (
        .clock    (clock),
        .reset    (reset),
        .req      (req),
        .ex_rec   (ex_rec),
        .mem_rec  (mem_rec),
        .wb_rec   (wb_rec),
        .id_stall (id_stall),
        .issue    (issue)
    );

    bind operand_fetch operand_fetch_assertions i_assertions (
        .clock       (clock),
        .reset       (reset),
        .inst_valid  (req.inst_valid),
        .id_stall    (id_stall),
        .issue_valid (issue.valid)
    );

    always #20 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic src_req_t make_req(input logic inst_valid, input logic r1_en,
                                          input reg_addr_t r1_addr, input logic r2_en,
                                          input reg_addr_t r2_addr);
        src_req_t r;
        r.inst_valid = inst_valid;
        r.r1_en      = r1_en;
        r.r1_addr    = r1_addr;
        r.r2_en      = r2_en;
        r.r2_addr    = r2_addr;
        return r;
    endfunction

    // valid record with write enable set
    function automatic fwd_rec_t make_rec(input logic is_load, input reg_addr_t addr,
                                          input data_t data);
        fwd_rec_t rec;
        rec.valid   = 1'b1;
        rec.rw_en   = 1'b1;
        rec.is_load = is_load;
        rec.rw_addr = addr;
        rec.rw_data = data;
        return rec;
    endfunction

    function automatic src_sel_e newest_match(input logic en, input reg_addr_t addr,
                                              input fwd_rec_t ex, input fwd_rec_t mem,
                                              input fwd_rec_t wb);
        if (!en || addr == 0) return src_zero;
        if (ex.valid && ex.rw_en && ex.rw_addr == addr) return src_ex;
        if (mem.valid && mem.rw_en && mem.rw_addr == addr) return src_mem;
        if (wb.valid && wb.rw_en && wb.rw_addr == addr) return src_wb;
        return src_rf;
    endfunction

    function automatic data_t operand_value(input src_sel_e sel, input reg_addr_t addr,
                                            input fwd_rec_t ex, input fwd_rec_t mem,
                                            input fwd_rec_t wb);
        case (sel)
            src_ex:  return ex.rw_data;
            src_mem: return mem.rw_data;
            src_wb:  return wb.rw_data;
            src_rf:  return shadow[addr];
            default: return '0;
        endcase
    endfunction

    task automatic check_stall(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: id_stall expected %b got %b",
                     $time, expected, actual);
            stall_errors++;
        end
    endtask

    task automatic check_issue(input issue_t expected, input issue_t actual);
        if (actual.valid !== expected.valid) begin
            $display("Mismatch at time %0t: issue.valid expected %b got %b",
                     $time, expected.valid, actual.valid);
            issue_errors++;
        end else if (expected.valid) begin
            if (actual.op1 !== expected.op1) begin
                $display("Mismatch at time %0t: issue.op1 expected %h got %h",
                         $time, expected.op1, actual.op1);
                issue_errors++;
            end
            if (actual.op2 !== expected.op2) begin
                $display("Mismatch at time %0t: issue.op2 expected %h got %h",
                         $time, expected.op2, actual.op2);
                issue_errors++;
            end
        end
    endtask

    // starts and ends on a falling edge and takes one clock
    task automatic apply_cycle(input src_req_t r, input fwd_rec_t ex, input fwd_rec_t mem,
                               input fwd_rec_t wb);
        src_sel_e sel1;
        src_sel_e sel2;
        logic     load_wait;
        logic     exp_stall;
        issue_t   exp_issue;
        sel1 = newest_match(r.r1_en, r.r1_addr, ex, mem, wb);
        sel2 = newest_match(r.r2_en, r.r2_addr, ex, mem, wb);
        load_wait = ((sel1 == src_ex || sel2 == src_ex) && ex.is_load)
                 || ((sel1 == src_mem || sel2 == src_mem) && mem.is_load);
        exp_stall = !r.inst_valid || load_wait;
        exp_issue.valid = !exp_stall;
        exp_issue.op1   = operand_value(sel1, r.r1_addr, ex, mem, wb);
        exp_issue.op2   = operand_value(sel2, r.r2_addr, ex, mem, wb);
        req     = r;
        ex_rec  = ex;
        mem_rec = mem;
        wb_rec  = wb;
        #5;
        check_stall(exp_stall, id_stall);
        @(negedge clock);
        if (wb.valid && wb.rw_en && wb.rw_addr != 0) begin
            shadow[wb.rw_addr] = wb.rw_data;
        end
        check_issue(exp_issue, issue);
    endtask

    task automatic write_then_read();
        fwd_rec_t idle;
        int       i;
        idle = '0;
        // registers read zero straight after reset
        apply_cycle(make_req(1, 1, 1, 1, 2), idle, idle, idle);
        // fill every register through writeback while decode idles
        for (i = 1; i < reg_count; i++) begin
            apply_cycle(make_req(0, 0, 0, 0, 0), idle, idle,
                        make_rec(1'b0, reg_addr_t'(i), data_t'($urandom())));
        end
        for (i = 1; i < reg_count; i++) begin
            apply_cycle(make_req(1, 1, reg_addr_t'(i), 1, reg_addr_t'(reg_count - i)),
                        idle, idle, idle);
        end
    endtask

    task automatic forward_priority();
        fwd_rec_t  idle;
        fwd_rec_t  ex;
        fwd_rec_t  mem;
        fwd_rec_t  wb;
        src_req_t  r;
        int        src;
        idle = '0;
        for (src = 1; src <= 3; src++) begin
            ex  = make_rec(1'b0, 7, $urandom());
            mem = make_rec(1'b0, 7, $urandom());
            wb  = make_rec(1'b0, 7, $urandom());
            // src 3 reads the same register on both ports
            if (src == 1) r = make_req(1, 1, 7, 1, 12);
            else if (src == 2) r = make_req(1, 1, 12, 1, 7);
            else r = make_req(1, 1, 7, 1, 7);
            apply_cycle(r, ex, mem, wb);
            ex.valid = 1'b0;
            apply_cycle(r, ex, mem, wb);
            mem.valid = 1'b0;
            apply_cycle(r, ex, mem, wb);
            // wb data has landed in the register file by now
            apply_cycle(r, idle, idle, idle);
        end
    endtask

    task automatic zero_and_disabled();
        fwd_rec_t idle;
        idle = '0;
        apply_cycle(make_req(1, 1, 0, 1, 0), make_rec(1'b0, 0, $urandom()),
                    make_rec(1'b1, 0, $urandom()), idle);
        // loads aimed at disabled sources
        apply_cycle(make_req(1, 0, 9, 0, 14), make_rec(1'b1, 9, $urandom()),
                    make_rec(1'b1, 14, $urandom()), idle);
        // r0 write attempt followed by a read back
        apply_cycle(make_req(1, 1, 0, 0, 0), idle, idle, make_rec(1'b0, 0, $urandom()));
        apply_cycle(make_req(1, 1, 0, 1, 0), idle, idle, idle);
    endtask

    task automatic load_use_stall();
        fwd_rec_t idle;
        fwd_rec_t ld;
        src_req_t r;
        idle = '0;
        r = make_req(1, 1, 5, 1, 6);
        apply_cycle(r, make_rec(1'b1, 5, $urandom()), idle, idle);
        apply_cycle(r, make_rec(1'b1, 6, $urandom()), idle, idle);
        apply_cycle(r, idle, make_rec(1'b1, 5, $urandom()), idle);
        apply_cycle(r, idle, make_rec(1'b1, 6, $urandom()), idle);
        // newer alu result in ex hides the older load in mem
        apply_cycle(r, make_rec(1'b0, 6, $urandom()), make_rec(1'b1, 6, $urandom()), idle);
        ld = make_rec(1'b1, 5, $urandom());
        apply_cycle(r, idle, idle, ld);
        apply_cycle(r, idle, idle, idle);
    endtask

    task automatic invalid_instruction();
        fwd_rec_t idle;
        idle = '0;
        apply_cycle(make_req(0, 1, 3, 1, 4), idle, idle, idle);
        apply_cycle(make_req(0, 0, 0, 0, 0), idle, idle, idle);
        apply_cycle(make_req(1, 1, 3, 1, 4), idle, idle, idle);
    endtask

    initial begin
        issue_t after_reset;
        void'($urandom(40));
        clock   = 1'b0;
        reset   = 1'b1;
        req     = '0;
        ex_rec  = '0;
        mem_rec = '0;
        wb_rec  = '0;
        for (int i = 0; i < reg_count; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        after_reset = '0;
        check_issue(after_reset, issue);

        write_then_read();
        forward_priority();
        zero_and_disabled();
        load_use_stall();
        invalid_instruction();

        assertion_errors = i_dut.i_assertions.failures;
        total_errors = stall_errors + issue_errors + assertion_errors;
        $display("errors: %0d (stall %0d, issue %0d, assertion %0d)",
                 total_errors, stall_errors, issue_errors, assertion_errors);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : operand_fetch_tb

//--- filelist.f
logic/core_pkg.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/operand_issue.sv
logic/operand_fetch.sv
tests/operand_fetch_assertions.sv
tests/operand_fetch_tb.sv

//--- Bender.yml
package:
  name: operand_fetch

sources:
  - logic/core_pkg.sv
  - logic/reg_file.sv
  - logic/operand_bypass.sv
  - logic/operand_issue.sv
  - logic/operand_fetch.sv
  - target: test
    files:
      - tests/operand_fetch_assertions.sv
      - tests/operand_fetch_tb.sv
